//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP ?= tb_wb_vga
FILELIST ?= filelist.f
LOG ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- filelist.f
vga_pkg.sv
vga_beam_if.sv
vga_regs.sv
vga_timing.sv
vga_fetch.sv
vga_line_fifo.sv
vga_pixel_out.sv
wb_vga.sv
tb_vram.sv
tb_wb_vga.sv

//--- tb_vram.sv
`default_nettype none
`timescale 1ns/1ps

// frame buffer model, one classic read at a time with 0 to 2 wait cycles
module tb_vram (
	input  logic clk_i,
	input  logic rst,
	input  logic cyc_i,
	input  logic stb_i,
	input  logic [29:0] addr_i,
	output logic [31:0] data_o,
	output logic ack_o
);

	logic [31:0] lfsr_q = 32'hc665_b0a5;
	logic [31:0] data_q = '0;
	logic ack_q = 1'b0;
	logic busy_q = 1'b0;
	int wait_q = 0;

	assign data_o = data_q;
	assign ack_o = ack_q;

	// contents, every address bit reaches the word
	function automatic logic [31:0] word_at(input logic [29:0] addr);
		return ({2'b00, addr} * 32'h9e37_79b1) ^ {addr, 2'b11};
	endfunction

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return {1'b0, s[31:1]} ^ 32'h8020_0003;
		return {1'b0, s[31:1]};
	endfunction

	task automatic take_delay(output int d);
		logic [1:0] bits;
		for (int i = 0; i < 2; i++) begin
			bits[i] = lfsr_q[0];
			lfsr_q = lfsr_next(lfsr_q);  // one step per bit
		end
		d = int'(bits) % 3;
	endtask

	// driven on the falling edge, sampled by the DUT on the rising one
	always @(negedge clk_i) begin
		if (rst) begin
			ack_q = 1'b0;
			busy_q = 1'b0;
			wait_q = 0;
		end else if (ack_q) begin
			ack_q = 1'b0;  // single beat
		end else if (cyc_i && stb_i) begin
			if (!busy_q) begin
				busy_q = 1'b1;
				take_delay(wait_q);
			end
			if (wait_q == 0) begin
				ack_q = 1'b1;
				data_q = word_at(addr_i);
				busy_q = 1'b0;
			end else begin
				wait_q = wait_q - 1;
			end
		end
	end

endmodule

`default_nettype wire

//--- tb_wb_vga.sv
`default_nettype none
`timescale 1ns/1ps

module tb_wb_vga;

	logic wbs_clk_i = 1'b0;
	logic rst;
	logic wbs_cs_i;
	logic [vga_pkg::DEV_ADDR_BITS-1:2] wbs_addr_i;
	logic [3:0] wbs_sel_i;
	logic wbs_we_i;
	logic [31:0] wbs_data_i;
	logic [31:0] wbs_data_o;
	logic wbs_ack_o;
	logic wbm_cyc_o;
	logic wbm_stb_o;
	logic [29:0] wbm_addr_o;
	logic [3:0] wbm_sel_o;
	logic wbm_we_o;
	logic [31:0] wbm_data_i;
	logic wbm_ack_i;
	logic h_sync_o;
	logic v_sync_o;
	logic [2:0] r_color_o;
	logic [2:0] g_color_o;
	logic [1:0] b_color_o;

	int word_errs = 0;
	int pixel_errs = 0;
	int bit_errs = 0;
	logic [31:0] base_val = '0;  // byte base picked up at the next frame
	logic [29:0] frame_base = '0;
	int frames_seen = 0;
	int trk_h = 0;
	int trk_v = 0;
	logic vs_prev = 1'b1;

	always #4 wbs_clk_i = ~wbs_clk_i;

	wb_vga DUT (.*);

	tb_vram u_vram (.clk_i(wbs_clk_i), .rst(rst), .cyc_i(wbm_cyc_o), .stb_i(wbm_stb_o),
		.addr_i(wbm_addr_o), .data_o(wbm_data_i), .ack_o(wbm_ack_i));

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			word_errs++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_pixel(input string name, input vga_pkg::pixel_t got,
			input vga_pkg::pixel_t exp);
		if (got !== exp) begin
			pixel_errs++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			bit_errs++;
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// expected colour of an active pixel, word base + v*8 + h/4, byte h%4
	function automatic vga_pkg::pixel_t ref_pixel(input logic [29:0] base, input int h,
			input int v);
		logic [31:0] w;
		logic [7:0] b8;
		vga_pkg::pixel_t p;
		w = u_vram.word_at(base + 30'(v * (vga_pkg::H_ACTIVE / vga_pkg::PIX_PER_WORD)
			+ h / vga_pkg::PIX_PER_WORD));
		b8 = w[8 * (h % vga_pkg::PIX_PER_WORD) +: 8];
		p.r = b8[7:5];
		p.g = b8[4:2];
		p.b = b8[1:0];
		return p;
	endfunction

	task automatic bus_access(input logic we, input int addr, input logic [3:0] sel,
			input logic [31:0] wdata, output logic [31:0] rdata);
		check_bit("wbs_ack_o", wbs_ack_o, 1'b0);
		wbs_cs_i = 1'b1;
		wbs_we_i = we;
		wbs_addr_i = vga_pkg::REG_ADDR_W'(addr);
		wbs_sel_i = sel;
		wbs_data_i = wdata;
		@(negedge wbs_clk_i);
		check_bit("wbs_ack_o", wbs_ack_o, 1'b1);  // exactly one cycle after cs
		rdata = wbs_data_o;
		wbs_cs_i = 1'b0;
		wbs_we_i = 1'b0;
		@(negedge wbs_clk_i);
	endtask

	task automatic reg_write(input int addr, input logic [3:0] sel, input logic [31:0] wdata);
		logic [31:0] unused;
		bus_access(1'b1, addr, sel, wdata, unused);
	endtask

	task automatic read_expect(input int addr, input logic [31:0] exp);
		logic [31:0] rd;
		bus_access(1'b0, addr, 4'hf, 32'h0, rd);
		check_word("wbs_data_o", rd, exp);
	endtask

	task automatic hold_idle(input int n);
		repeat (n) begin
			@(negedge wbs_clk_i);
			check_bit("wbm_cyc_o", wbm_cyc_o, 1'b0);
			check_bit("wbm_stb_o", wbm_stb_o, 1'b0);
			check_bit("h_sync_o", h_sync_o, 1'b1);
			check_bit("v_sync_o", v_sync_o, 1'b1);
			check_pixel("colour", {r_color_o, g_color_o, b_color_o}, '0);
		end
	endtask

	task automatic await_frames(input int n);
		int target;
		target = frames_seen + n;
		while (frames_seen < target)
			@(negedge wbs_clk_i);
	endtask

	task automatic seek_line(input int l);
		while (!(trk_v == l && trk_h == 0))
			@(negedge wbs_clk_i);
	endtask

	task automatic finish_run(input bit timed_out);
		$display("errors: word %0d pixel %0d bit %0d", word_errs, pixel_errs, bit_errs);
		if (!timed_out && word_errs + pixel_errs + bit_errs == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	endtask

	// beam tracker and compare, locked to the falling edge of v_sync_o
	always @(negedge wbs_clk_i) begin : compare
		int h_n;
		int v_n;
		logic exp_hs;
		logic exp_vs;
		vga_pkg::pixel_t exp_pix;
		h_n = trk_h + 1;
		v_n = trk_v;
		if (h_n == vga_pkg::H_TOTAL) begin
			h_n = 0;
			v_n = (trk_v + 1) % vga_pkg::V_TOTAL;
		end
		if (!rst && vs_prev === 1'b1 && v_sync_o === 1'b0) begin
			h_n = 0;
			v_n = vga_pkg::V_SYNC_START;
			frames_seen <= frames_seen + 1;
			frame_base <= base_val[31:2];  // fetch reloads here
		end
		if (wbm_cyc_o === 1'b1) begin
			check_bit("wbm_stb_o", wbm_stb_o, 1'b1);  // classic read, stb with cyc
			check_bit("wbm_we_o", wbm_we_o, 1'b0);
			check_bit("wbm_sel_o all ones", &wbm_sel_o, 1'b1);
		end else begin
			check_bit("wbm_stb_o", wbm_stb_o, 1'b0);
		end
		if (frames_seen > 0) begin
			exp_hs = !(h_n >= vga_pkg::H_SYNC_START
				&& h_n < vga_pkg::H_SYNC_START + vga_pkg::H_SYNC);
			exp_vs = !(v_n >= vga_pkg::V_SYNC_START
				&& v_n < vga_pkg::V_SYNC_START + vga_pkg::V_SYNC);
			if (h_n < vga_pkg::H_ACTIVE && v_n < vga_pkg::V_ACTIVE)
				exp_pix = ref_pixel(frame_base, h_n, v_n);
			else
				exp_pix = '0;  // blanking
			check_bit("h_sync_o", h_sync_o, exp_hs);
			check_bit("v_sync_o", v_sync_o, exp_vs);
			check_pixel("colour", {r_color_o, g_color_o, b_color_o}, exp_pix);
		end
		vs_prev <= v_sync_o;
		trk_h <= h_n;
		trk_v <= v_n;
	end

	initial begin : stimulus
		logic [31:0] fc1;
		logic [31:0] fc2;
		rst = 1'b1;
		wbs_cs_i = 1'b0;
		wbs_addr_i = '0;
		wbs_sel_i = '0;
		wbs_we_i = 1'b0;
		wbs_data_i = '0;
		repeat (16) @(negedge wbs_clk_i);
		rst = 1'b0;
		hold_idle(4);
		read_expect(vga_pkg::REG_MODE, 32'h0);
		read_expect(vga_pkg::REG_BASE, 32'h0);
		read_expect(vga_pkg::REG_STATUS, 32'h0);
		// merged byte writes, enable bit kept clear
		reg_write(vga_pkg::REG_MODE, 4'b0101, 32'h1234_5670);
		read_expect(vga_pkg::REG_MODE, 32'h0034_0070);
		reg_write(vga_pkg::REG_MODE, 4'b1010, 32'habcd_ef00);
		read_expect(vga_pkg::REG_MODE, 32'hab34_ef70);
		reg_write(vga_pkg::REG_BASE, 4'b0011, 32'hdead_beef);
		read_expect(vga_pkg::REG_BASE, 32'h0000_beef);
		reg_write(vga_pkg::REG_BASE, 4'b1100, 32'h0012_0000);
		read_expect(vga_pkg::REG_BASE, 32'h0012_beef);
		reg_write(vga_pkg::REG_STATUS, 4'hf, 32'hffff_ffff);
		read_expect(vga_pkg::REG_STATUS, 32'h0);
		hold_idle(vga_pkg::H_TOTAL * vga_pkg::V_TOTAL);

		base_val = 32'h0000_0400;
		reg_write(vga_pkg::REG_BASE, 4'hf, base_val);
		reg_write(vga_pkg::REG_MODE, 4'hf, 32'h0000_0001);
		await_frames(1);
		seek_line(3);
		bus_access(1'b0, vga_pkg::REG_STATUS, 4'hf, 32'h0, fc1);
		check_bit("STATUS underrun", fc1[0], 1'b0);
		// new base mid frame, current frame keeps the old one
		base_val = 32'h0000_1000;
		reg_write(vga_pkg::REG_BASE, 4'hf, base_val);
		await_frames(2);
		seek_line(3);
		bus_access(1'b0, vga_pkg::REG_STATUS, 4'hf, 32'h0, fc2);
		check_bit("STATUS underrun", fc2[0], 1'b0);
		check_word("STATUS frame count", {24'h0, fc2[23:16]}, {24'h0, fc1[23:16] + 8'd2});
		finish_run(1'b0);
	end

	initial begin : watchdog
		repeat (6 * vga_pkg::H_TOTAL * vga_pkg::V_TOTAL + 400) @(posedge wbs_clk_i);
		$display("watchdog expired, the test sequence did not complete in time");
		finish_run(1'b1);
	end

endmodule

`default_nettype wire

//--- vga_beam_if.sv
`default_nettype none
`timescale 1ns/1ps

// beam position and sync levels, syncs active low
interface vga_beam_if;

	logic [vga_pkg::H_CNT_W-1:0] h_count;
	logic [vga_pkg::V_CNT_W-1:0] v_count;
	logic active;
	logic h_sync;
	logic v_sync;
	logic frame_start;  // first cycle of vertical sync

	modport src (
		output h_count, v_count, active, h_sync, v_sync, frame_start
	);

	modport snk (
		input h_count, v_count, active, h_sync, v_sync, frame_start
	);

endinterface

`default_nettype wire

//--- vga_fetch.sv
`default_nettype none
`timescale 1ns/1ps

module vga_fetch (
	input  logic wbs_clk_i,
	input  logic rst,
	input  logic enable_i,
	input  logic [29:0] vram_base_i,
	vga_beam_if.snk beam,
	output logic wr_en_o,
	output logic [31:0] wr_data_o,
	input  logic full_i,
	output logic flush_o,
	output logic wbm_cyc_o,
	output logic wbm_stb_o,
	output logic [29:0] wbm_addr_o,
	output logic [3:0] wbm_sel_o,
	output logic wbm_we_o,
	input  logic [31:0] wbm_data_i,
	input  logic wbm_ack_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_DRAIN  // frame restart seen, waiting out the open access
	} state_t;

	state_t state_q;
	logic [29:0] addr_q;
	logic [vga_pkg::WORD_CNT_W-1:0] cnt_q;
	logic flush_q;
	logic reload;
	logic frame_done;

	// restart once no access is outstanding
	assign reload = (state_q == ST_IDLE && beam.frame_start)
		|| (state_q == ST_REQ && wbm_ack_i && beam.frame_start)
		|| (state_q == ST_DRAIN && wbm_ack_i);
	assign frame_done = cnt_q == vga_pkg::WORD_CNT_W'(vga_pkg::WORDS_PER_FRAME);

	assign wbm_cyc_o = state_q != ST_IDLE;
	assign wbm_stb_o = wbm_cyc_o;
	assign wbm_addr_o = addr_q;
	assign wbm_sel_o = 4'hf;
	assign wbm_we_o = 1'b0;  // read only

	assign wr_en_o = state_q == ST_REQ && wbm_ack_i && !beam.frame_start;
	assign wr_data_o = wbm_data_i;
	assign flush_o = flush_q;

	always_ff @(posedge wbs_clk_i) begin
		if (rst) begin
			state_q <= ST_IDLE;
			addr_q <= '0;
			cnt_q <= vga_pkg::WORD_CNT_W'(vga_pkg::WORDS_PER_FRAME);  // idle until a frame
			flush_q <= 1'b0;
		end else begin
			flush_q <= reload;
			if (reload) begin
				state_q <= ST_IDLE;
				addr_q <= vram_base_i;  // base latched once per frame
				cnt_q <= '0;
			end else begin
				case (state_q)
					ST_IDLE: begin
						if (enable_i && !frame_done && !full_i)
							state_q <= ST_REQ;
					end
					ST_REQ: begin
						if (beam.frame_start) begin
							state_q <= ST_DRAIN;
						end else if (wbm_ack_i) begin
							state_q <= ST_IDLE;
							addr_q <= addr_q + 30'd1;
							cnt_q <= cnt_q + 1'b1;
						end
					end
					ST_DRAIN: ;  // left through reload
					default: state_q <= ST_IDLE;
				endcase
			end
		end
	end

	a_stb_held: assert property (@(posedge wbs_clk_i) disable iff (rst)
		$fell(wbm_stb_o) |-> $past(wbm_ack_i));

endmodule

`default_nettype wire

//--- vga_line_fifo.sv
`default_nettype none
`timescale 1ns/1ps

module vga_line_fifo (
	input  logic wbs_clk_i,
	input  logic rst,
	input  logic flush_i,
	input  logic wr_en_i,
	input  logic [31:0] wr_data_i,
	output logic full_o,
	input  logic rd_en_i,
	output logic [31:0] rd_data_o,
	output logic empty_o
);

	localparam int AW = vga_pkg::FIFO_AW;

	logic [31:0] mem [vga_pkg::FIFO_DEPTH];
	logic [AW:0] wr_ptr_q;  // extra bit tells full from empty
	logic [AW:0] rd_ptr_q;

	assign empty_o = wr_ptr_q == rd_ptr_q;
	assign full_o = wr_ptr_q[AW] != rd_ptr_q[AW] && wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0];
	assign rd_data_o = mem[rd_ptr_q[AW-1:0]];  // head word, show-ahead

	always_ff @(posedge wbs_clk_i) begin
		if (wr_en_i && !full_o)
			mem[wr_ptr_q[AW-1:0]] <= wr_data_i;
	end

	always_ff @(posedge wbs_clk_i) begin
		if (rst || flush_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			if (wr_en_i && !full_o)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (rd_en_i && !empty_o)
				rd_ptr_q <= rd_ptr_q + 1'b1;
		end
	end

	a_no_overflow: assert property (@(posedge wbs_clk_i) disable iff (rst)
		wr_en_i |-> !full_o);

	a_no_underflow: assert property (@(posedge wbs_clk_i) disable iff (rst)
		rd_en_i |-> !empty_o);

endmodule

`default_nettype wire

//--- vga_pixel_out.sv
`default_nettype none
`timescale 1ns/1ps

module vga_pixel_out (
	input  logic wbs_clk_i,
	input  logic rst,
	vga_beam_if.snk beam,
	output logic rd_en_o,
	input  logic [31:0] rd_data_i,
	input  logic empty_i,
	output logic underrun_o,
	output logic h_sync_o,
	output logic v_sync_o,
	output vga_pkg::pixel_t pixel_o
);

	logic [vga_pkg::PIX_SEL_W-1:0] pix_sel;
	logic [7:0] pix_byte;
	logic last_pix;
	logic armed_q;  // set once the fetch has had a frame start

	assign pix_sel = beam.h_count[vga_pkg::PIX_SEL_W-1:0];
	assign pix_byte = rd_data_i[8*pix_sel +: 8];
	assign last_pix = pix_sel == vga_pkg::PIX_SEL_W'(vga_pkg::PIX_PER_WORD - 1);

	assign rd_en_o = beam.active && last_pix && !empty_i;  // word used up
	assign underrun_o = armed_q && beam.active && empty_i;

	always_ff @(posedge wbs_clk_i) begin
		if (rst) begin
			armed_q <= 1'b0;
			pixel_o <= '0;
			h_sync_o <= 1'b1;
			v_sync_o <= 1'b1;
		end else begin
			if (beam.frame_start)
				armed_q <= 1'b1;
			// black in blanking and on a missing word
			if (beam.active && !empty_i)
				pixel_o <= vga_pkg::pixel_t'(pix_byte);
			else
				pixel_o <= '0;
			h_sync_o <= beam.h_sync;  // keep syncs level with colour
			v_sync_o <= beam.v_sync;
		end
	end

endmodule

`default_nettype wire

//--- vga_pkg.sv
`default_nettype none

package vga_pkg;

	// horizontal phases in pixel clocks, active first
	localparam int H_ACTIVE = 32;
	localparam int H_FP = 4;
	localparam int H_SYNC = 8;
	localparam int H_BP = 4;
	localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
	localparam int H_SYNC_START = H_ACTIVE + H_FP;

	// vertical phases in lines
	localparam int V_ACTIVE = 8;
	localparam int V_FP = 1;
	localparam int V_SYNC = 2;
	localparam int V_BP = 2;
	localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
	localparam int V_SYNC_START = V_ACTIVE + V_FP;

	localparam int H_CNT_W = $clog2(H_TOTAL);
	localparam int V_CNT_W = $clog2(V_TOTAL);

	// frame buffer layout, byte 0 of a word is the leftmost pixel
	localparam int PIX_PER_WORD = 4;
	localparam int PIX_SEL_W = $clog2(PIX_PER_WORD);
	localparam int WORDS_PER_FRAME = H_ACTIVE * V_ACTIVE / PIX_PER_WORD;
	localparam int WORD_CNT_W = $clog2(WORDS_PER_FRAME + 1);

	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);

	// slave register map, word addresses
	localparam int DEV_ADDR_BITS = 8;
	localparam int REG_ADDR_W = DEV_ADDR_BITS - 2;
	localparam int REG_MODE = 0;
	localparam int REG_BASE = 1;
	localparam int REG_STATUS = 2;
	localparam int MODE_EN_BIT = 0;

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
	} pixel_t;

endpackage

`default_nettype wire

//--- vga_regs.sv
`default_nettype none
`timescale 1ns/1ps

module vga_regs (
	input  logic wbs_clk_i,
	input  logic rst,
	input  logic wbs_cs_i,
	input  logic [vga_pkg::DEV_ADDR_BITS-1:2] wbs_addr_i,
	input  logic [3:0] wbs_sel_i,
	input  logic wbs_we_i,
	input  logic [31:0] wbs_data_i,
	output logic [31:0] wbs_data_o,
	output logic wbs_ack_o,
	input  logic underrun_i,
	input  logic frame_start_i,
	output logic enable_o,
	output logic [29:0] vram_base_o
);

	logic [31:0] mode_q;
	logic [31:0] base_q;  // byte address of the frame buffer
	logic underrun_q;
	logic [7:0] frame_cnt_q;
	logic [31:0] status;
	logic [31:0] rd_val;
	logic access;
	logic wr_stb;

	function automatic logic [31:0] byte_merge(input logic [31:0] old_v,
			input logic [31:0] new_v, input logic [3:0] sel);
		logic [31:0] res;
		res = old_v;
		for (int i = 0; i < 4; i++) begin
			if (sel[i])
				res[8*i +: 8] = new_v[8*i +: 8];
		end
		return res;
	endfunction

	assign access = wbs_cs_i & ~wbs_ack_o;
	assign wr_stb = access & wbs_we_i;
	assign status = {8'h00, frame_cnt_q, 15'h0000, underrun_q};
	assign enable_o = mode_q[vga_pkg::MODE_EN_BIT];
	assign vram_base_o = base_q[31:2];

	always_comb begin
		case (wbs_addr_i)
			vga_pkg::REG_ADDR_W'(vga_pkg::REG_MODE):   rd_val = mode_q;
			vga_pkg::REG_ADDR_W'(vga_pkg::REG_BASE):   rd_val = base_q;
			vga_pkg::REG_ADDR_W'(vga_pkg::REG_STATUS): rd_val = status;
			default:                                   rd_val = '0;
		endcase
	end

	always_ff @(posedge wbs_clk_i) begin
		if (rst) begin
			wbs_ack_o <= 1'b0;
			mode_q <= '0;
			base_q <= '0;
			underrun_q <= 1'b0;
			frame_cnt_q <= '0;
		end else begin
			wbs_ack_o <= access;  // one ack per access, then a gap
			if (frame_start_i)
				frame_cnt_q <= frame_cnt_q + 8'd1;
			if (underrun_i)
				underrun_q <= 1'b1;  // a new underrun beats the clear
			else if (wr_stb && wbs_addr_i == vga_pkg::REG_ADDR_W'(vga_pkg::REG_STATUS)
					&& wbs_sel_i[0] && wbs_data_i[0])
				underrun_q <= 1'b0;
			if (wr_stb && wbs_addr_i == vga_pkg::REG_ADDR_W'(vga_pkg::REG_MODE))
				mode_q <= byte_merge(mode_q, wbs_data_i, wbs_sel_i);
			if (wr_stb && wbs_addr_i == vga_pkg::REG_ADDR_W'(vga_pkg::REG_BASE))
				base_q <= byte_merge(base_q, wbs_data_i, wbs_sel_i);
		end
	end

	// read data travels with the ack
	always_ff @(posedge wbs_clk_i) begin
		if (access)
			wbs_data_o <= rd_val;
	end

	a_ack_single: assert property (@(posedge wbs_clk_i) disable iff (rst)
		wbs_ack_o |=> !wbs_ack_o);

endmodule

`default_nettype wire

//--- vga_timing.sv
`default_nettype none
`timescale 1ns/1ps

module vga_timing (
	input  logic wbs_clk_i,
	input  logic rst,
	input  logic enable_i,
	vga_beam_if.src beam
);

	logic [vga_pkg::H_CNT_W-1:0] h_nxt;
	logic [vga_pkg::V_CNT_W-1:0] v_nxt;
	logic h_act_nxt;
	logic v_act_nxt;
	logic h_sync_nxt;
	logic v_sync_nxt;

	// next beam position, parked at zero while disabled
	always_comb begin
		h_nxt = '0;
		v_nxt = '0;
		if (enable_i) begin
			if (beam.h_count == vga_pkg::H_CNT_W'(vga_pkg::H_TOTAL - 1)) begin
				h_nxt = '0;
				if (beam.v_count == vga_pkg::V_CNT_W'(vga_pkg::V_TOTAL - 1))
					v_nxt = '0;
				else
					v_nxt = beam.v_count + 1'b1;
			end else begin
				h_nxt = beam.h_count + 1'b1;
				v_nxt = beam.v_count;
			end
		end
	end

	assign h_act_nxt = h_nxt < vga_pkg::H_CNT_W'(vga_pkg::H_ACTIVE);
	assign v_act_nxt = v_nxt < vga_pkg::V_CNT_W'(vga_pkg::V_ACTIVE);
	assign h_sync_nxt = h_nxt >= vga_pkg::H_CNT_W'(vga_pkg::H_SYNC_START)
		&& h_nxt < vga_pkg::H_CNT_W'(vga_pkg::H_SYNC_START + vga_pkg::H_SYNC);
	assign v_sync_nxt = v_nxt >= vga_pkg::V_CNT_W'(vga_pkg::V_SYNC_START)
		&& v_nxt < vga_pkg::V_CNT_W'(vga_pkg::V_SYNC_START + vga_pkg::V_SYNC);

	always_ff @(posedge wbs_clk_i) begin
		if (rst) begin
			beam.h_count <= '0;
			beam.v_count <= '0;
			beam.active <= 1'b0;
			beam.h_sync <= 1'b1;
			beam.v_sync <= 1'b1;
			beam.frame_start <= 1'b0;
		end else begin
			beam.h_count <= h_nxt;
			beam.v_count <= v_nxt;
			beam.active <= enable_i & h_act_nxt & v_act_nxt;
			beam.h_sync <= ~(enable_i & h_sync_nxt);  // active low
			beam.v_sync <= ~(enable_i & v_sync_nxt);
			beam.frame_start <= enable_i && h_nxt == '0
				&& v_nxt == vga_pkg::V_CNT_W'(vga_pkg::V_SYNC_START);
		end
	end

	a_frame_start_at_line_start: assert property (@(posedge wbs_clk_i) disable iff (rst)
		beam.frame_start |-> beam.h_count == '0 && $fell(beam.v_sync));

endmodule

`default_nettype wire

//--- wb_vga.sv
`default_nettype none
`timescale 1ns/1ps

module wb_vga (
	input  logic wbs_clk_i,
	input  logic rst,
	// register slave
	input  logic wbs_cs_i,
	input  logic [vga_pkg::DEV_ADDR_BITS-1:2] wbs_addr_i,
	input  logic [3:0] wbs_sel_i,
	input  logic wbs_we_i,
	input  logic [31:0] wbs_data_i,
	output logic [31:0] wbs_data_o,
	output logic wbs_ack_o,
	// frame buffer master, word addressed
	output logic wbm_cyc_o,
	output logic wbm_stb_o,
	output logic [29:0] wbm_addr_o,
	output logic [3:0] wbm_sel_o,
	output logic wbm_we_o,
	input  logic [31:0] wbm_data_i,
	input  logic wbm_ack_i,
	// display
	output logic h_sync_o,
	output logic v_sync_o,
	output logic [2:0] r_color_o,
	output logic [2:0] g_color_o,
	output logic [1:0] b_color_o
);

	logic enable;
	logic [29:0] vram_base;
	logic underrun;
	logic fifo_wr_en;
	logic [31:0] fifo_wr_data;
	logic fifo_full;
	logic fifo_rd_en;
	logic [31:0] fifo_rd_data;
	logic fifo_empty;
	logic fifo_flush;
	vga_pkg::pixel_t pixel;

	vga_beam_if beam ();

	vga_regs u_regs (
		.wbs_clk_i(wbs_clk_i), .rst(rst),
		.wbs_cs_i(wbs_cs_i), .wbs_addr_i(wbs_addr_i), .wbs_sel_i(wbs_sel_i),
		.wbs_we_i(wbs_we_i), .wbs_data_i(wbs_data_i), .wbs_data_o(wbs_data_o),
		.wbs_ack_o(wbs_ack_o), .underrun_i(underrun), .frame_start_i(beam.frame_start),
		.enable_o(enable), .vram_base_o(vram_base)
	);

	vga_timing u_timing (.wbs_clk_i(wbs_clk_i), .rst(rst), .enable_i(enable), .beam(beam));

	vga_fetch u_fetch (
		.wbs_clk_i(wbs_clk_i), .rst(rst), .enable_i(enable), .vram_base_i(vram_base),
		.beam(beam), .wr_en_o(fifo_wr_en), .wr_data_o(fifo_wr_data), .full_i(fifo_full),
		.flush_o(fifo_flush), .wbm_cyc_o(wbm_cyc_o), .wbm_stb_o(wbm_stb_o),
		.wbm_addr_o(wbm_addr_o), .wbm_sel_o(wbm_sel_o), .wbm_we_o(wbm_we_o),
		.wbm_data_i(wbm_data_i), .wbm_ack_i(wbm_ack_i)
	);

	vga_line_fifo u_fifo (
		.wbs_clk_i(wbs_clk_i), .rst(rst), .flush_i(fifo_flush),
		.wr_en_i(fifo_wr_en), .wr_data_i(fifo_wr_data), .full_o(fifo_full),
		.rd_en_i(fifo_rd_en), .rd_data_o(fifo_rd_data), .empty_o(fifo_empty)
	);

	vga_pixel_out u_pixel (
		.wbs_clk_i(wbs_clk_i), .rst(rst), .beam(beam),
		.rd_en_o(fifo_rd_en), .rd_data_i(fifo_rd_data), .empty_i(fifo_empty),
		.underrun_o(underrun), .h_sync_o(h_sync_o), .v_sync_o(v_sync_o), .pixel_o(pixel)
	);

	assign r_color_o = pixel.r;
	assign g_color_o = pixel.g;
	assign b_color_o = pixel.b;

endmodule

`default_nettype wire
